/* cache_arbiter.f */
hdl/rv32i_types.sv
hdl/mem_bus_pkg.sv
hdl/arbiter_control.sv
hdl/cacheline_adaptor.sv
hdl/cache_arbiter.sv
tb/cache_arbiter_properties.sv
tb/cache_arbiter_tb.sv

/* Makefile */
SOURCES := $(shell cat cache_arbiter.f)

.PHONY: all run clean

all: obj_dir/Vcache_arbiter_tb

obj_dir/Vcache_arbiter_tb: $(SOURCES) cache_arbiter.f
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module cache_arbiter_tb -f cache_arbiter.f

run: obj_dir/Vcache_arbiter_tb
	-obj_dir/Vcache_arbiter_tb > sim.log 2>&1
	cat sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb/cache_arbiter_tb.sv */
`timescale 1ns/1ns

module cache_arbiter_tb;

    localparam int RESP_TIMEOUT = 300; // Cycles
    localparam rv32i_types::rv32i_addr REGION = 32'h0000_4000;

    logic clk = 1'b0;
    logic rst;
    mem_bus_pkg::line_req_t icache_req;
    mem_bus_pkg::line_req_t dcache_req;
    mem_bus_pkg::pmem_rsp_t pmem_rsp;
    mem_bus_pkg::line_rsp_t icache_rsp;
    mem_bus_pkg::line_rsp_t dcache_rsp;
    mem_bus_pkg::pmem_req_t pmem_req;

    mem_bus_pkg::beat_t mem_beats [rv32i_types::rv32i_addr];
    mem_bus_pkg::line_t shadow_lines [rv32i_types::rv32i_addr];
    mem_bus_pkg::pmem_req_t beats_q [$]; // Beats served since the last line resp
    int unsigned lcg_state = 26;
    int cycle = 0;
    int requests_issued = 0;
    int responses_seen = 0;
    int icache_resp_cycle;
    int dcache_resp_cycle;
    int burst_start_cycle;
    logic pmem_was_busy = 1'b0;

    cache_arbiter dut_i
    (
        .clk          (clk),
        .rst          (rst),
        .icache_req_i (icache_req),
        .dcache_req_i (dcache_req),
        .pmem_rsp_i   (pmem_rsp),
        .icache_rsp_o (icache_rsp),
        .dcache_rsp_o (dcache_rsp),
        .pmem_req_o   (pmem_req)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    function automatic int unsigned rand_below(input int unsigned n);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) % n; // Upper bits have the longer period
    endfunction

    function automatic mem_bus_pkg::line_t random_line();
        mem_bus_pkg::line_t l;
        for (int k = 0; k < 16; k++)
            l[k*16 +: 16] = 16'(rand_below(32'h10000));
        return l;
    endfunction

    // Contents of a beat nobody has written yet
    function automatic mem_bus_pkg::beat_t init_beat(input rv32i_types::rv32i_addr a);
        return {a ^ 32'h5A5A_C3C3, ~a};
    endfunction

    function automatic mem_bus_pkg::line_t expected_line(input rv32i_types::rv32i_addr base);
        mem_bus_pkg::line_t l;
        if (shadow_lines.exists(base))
            return shadow_lines[base];
        for (int k = 0; k < mem_bus_pkg::BEATS_PER_LINE; k++)
            l[k*mem_bus_pkg::BEAT_WIDTH +: mem_bus_pkg::BEAT_WIDTH] = init_beat(base + 32'(8 * k));
        return l;
    endfunction

    task automatic abort_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_line(input string name, input mem_bus_pkg::line_t got,
                              input mem_bus_pkg::line_t exp);
        if (got !== exp)
        begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_beat_addr(input string name, input rv32i_types::rv32i_addr got,
                                   input rv32i_types::rv32i_addr exp);
        if (got !== exp)
        begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_response(input string who, input mem_bus_pkg::line_req_t req,
                                  input mem_bus_pkg::line_rsp_t rsp);
        mem_bus_pkg::pmem_req_t beat;
        mem_bus_pkg::line_t written;
        if (beats_q.size() != mem_bus_pkg::BEATS_PER_LINE)
        begin
            $display("%s resp came after %0d beats instead of 4", who, beats_q.size());
            abort_run();
        end
        for (int k = 0; k < mem_bus_pkg::BEATS_PER_LINE; k++)
        begin
            beat = beats_q.pop_front();
            check_beat_addr({who, " beat addr"}, beat.addr, req.addr + 32'(8 * k));
            check_flag({who, " beat read"}, beat.read, req.read);
            check_flag({who, " beat write"}, beat.write, req.write);
            written[k*mem_bus_pkg::BEAT_WIDTH +: mem_bus_pkg::BEAT_WIDTH] = beat.wdata;
        end
        if (req.write)
        begin
            check_line({who, " written line"}, written, req.wdata);
            shadow_lines[req.addr] = req.wdata;
        end
        else
            check_line({who, "_rsp.rdata"}, rsp.rdata, expected_line(req.addr));
        responses_seen++;
    endtask

    // Holds one cache's request until resp, then drops it and rests a cycle
    task automatic cache_access(input bit dside, input bit wr, input rv32i_types::rv32i_addr addr,
                                input mem_bus_pkg::line_t data);
        mem_bus_pkg::line_req_t req;
        int waited;
        bit got;
        req = '{read: !wr, write: wr, addr: addr, wdata: data};
        if (dside)
            dcache_req = req;
        else
            icache_req = req;
        requests_issued++;
        waited = 0;
        got = 1'b0;
        while (!got)
        begin
            @(negedge clk);
            got = dside ? dcache_rsp.resp : icache_rsp.resp;
            waited++;
            if (!got && waited > RESP_TIMEOUT)
            begin
                $display("Timeout: %s resp never came", dside ? "dcache" : "icache");
                abort_run();
            end
        end
        @(posedge clk);
        #1;
        if (dside)
            dcache_req = '0;
        else
            icache_req = '0;
        @(posedge clk);
        #1;
    endtask

    task automatic wait_pmem_busy();
        int waited;
        waited = 0;
        do
        begin
            @(negedge clk);
            waited++;
            if (waited > RESP_TIMEOUT)
            begin
                $display("Timeout: memory request never started");
                abort_run();
            end
        end
        while (!(pmem_req.read || pmem_req.write));
    endtask

    task automatic random_traffic(input bit dside, input int count);
        bit wr;
        int gap;
        rv32i_types::rv32i_addr a;
        for (int n = 0; n < count; n++)
        begin
            gap = int'(rand_below(4));
            repeat (gap)
            begin
                @(posedge clk);
                #1;
            end
            wr = dside && (rand_below(2) == 1); // I-cache only reads
            a = REGION + rv32i_types::rv32i_addr'(rand_below(8) * 32);
            cache_access(dside, wr, a, wr ? random_line() : '0);
        end
    endtask

    initial
    begin : memory_model
        mem_bus_pkg::pmem_req_t beat;
        int stall;
        pmem_rsp = '0;
        forever
        begin
            @(negedge clk);
            if (pmem_req.read || pmem_req.write)
            begin
                stall = int'(rand_below(4));
                repeat (stall) @(negedge clk);
                beat = pmem_req;
                beats_q.push_back(beat);
                if (beat.write)
                    mem_beats[beat.addr] = beat.wdata;
                @(posedge clk);
                #1;
                pmem_rsp.resp = 1'b1;
                if (beat.read)
                    pmem_rsp.rdata = mem_beats.exists(beat.addr) ? mem_beats[beat.addr]
                                                                 : init_beat(beat.addr);
                @(posedge clk);
                #1;
                pmem_rsp = '0;
            end
        end
    end

    always @(negedge clk)
    begin : compare_proc
        if (!rst)
        begin
            check_flag("icache_rsp.resp & dcache_rsp.resp",
                       icache_rsp.resp & dcache_rsp.resp, 1'b0);
            if (icache_rsp.resp)
            begin
                icache_resp_cycle = cycle;
                check_response("icache", icache_req, icache_rsp);
            end
            if (dcache_rsp.resp)
            begin
                dcache_resp_cycle = cycle;
                check_response("dcache", dcache_req, dcache_rsp);
            end
            if ((pmem_req.read || pmem_req.write) && !pmem_was_busy)
                burst_start_cycle = cycle;
            pmem_was_busy = pmem_req.read || pmem_req.write;
        end
    end

    initial
    begin : stimulus
        mem_bus_pkg::line_t wline;
        rst = 1'b1;
        icache_req = '0;
        dcache_req = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (5)
        begin
            @(negedge clk);
            check_flag("pmem_req.read", pmem_req.read, 1'b0);
            check_flag("pmem_req.write", pmem_req.write, 1'b0);
            check_flag("icache_rsp.resp", icache_rsp.resp, 1'b0);
            check_flag("dcache_rsp.resp", dcache_rsp.resp, 1'b0);
        end
        @(posedge clk);
        #1;

        cache_access(1'b0, 1'b0, REGION, '0);
        wline = random_line();
        cache_access(1'b1, 1'b1, REGION + 32'h20, wline);
        cache_access(1'b1, 1'b0, REGION + 32'h20, '0);

        // Same-cycle requests go I-cache first with a direct hand-off
        fork
            cache_access(1'b0, 1'b0, REGION + 32'h40, '0);
            cache_access(1'b1, 1'b0, REGION + 32'h20, '0);
        join
        check_flag("icache resp before dcache resp", icache_resp_cycle < dcache_resp_cycle, 1'b1);
        check_flag("dcache burst 2 cycles after icache resp",
                   burst_start_cycle == icache_resp_cycle + 2, 1'b1);

        fork
            cache_access(1'b1, 1'b0, REGION + 32'h60, '0);
            begin
                wait_pmem_busy();
                @(posedge clk);
                #1;
                cache_access(1'b0, 1'b0, REGION + 32'h80, '0);
            end
        join
        check_flag("dcache resp before icache resp", dcache_resp_cycle < icache_resp_cycle, 1'b1);

        fork
            random_traffic(1'b0, 20);
            random_traffic(1'b1, 20);
        join

        if (responses_seen != requests_issued || dut_i.arbiter_i.props_i.failures != 0)
        begin
            $display("%0d requests got %0d responses, %0d assertion failures",
                     requests_issued, responses_seen, dut_i.arbiter_i.props_i.failures);
            abort_run();
        end
        else
        begin
            $display("sim passed");
            $finish;
        end
    end

endmodule : cache_arbiter_tb

/* tb/cache_arbiter_properties.sv */
`timescale 1ns/1ns

module cache_arbiter_properties
(
    input logic                   clk,
    input logic                   rst,
    input mem_bus_pkg::line_req_t icache_req_i,
    input mem_bus_pkg::line_req_t dcache_req_i,
    input mem_bus_pkg::line_req_t line_req_i,
    input mem_bus_pkg::line_rsp_t icache_rsp_i,
    input mem_bus_pkg::line_rsp_t dcache_rsp_i
);

    int failures = 0; // Read by the testbench at the end of the run

    single_owner_resp: assert property (@(posedge clk) disable iff (rst)
        !(icache_rsp_i.resp && dcache_rsp_i.resp))
    else
    begin
        failures++;
        $error("icache and dcache resp high in the same cycle");
    end

    icache_resp_needs_req: assert property (@(posedge clk) disable iff (rst)
        icache_rsp_i.resp |-> (icache_req_i.read || icache_req_i.write))
    else
    begin
        failures++;
        $error("icache resp without an icache request");
    end

    dcache_resp_needs_req: assert property (@(posedge clk) disable iff (rst)
        dcache_rsp_i.resp |-> (dcache_req_i.read || dcache_req_i.write))
    else
    begin
        failures++;
        $error("dcache resp without a dcache request");
    end

    routed_req_one_op: assert property (@(posedge clk) disable iff (rst)
        !(line_req_i.read && line_req_i.write))
    else
    begin
        failures++;
        $error("routed line request has read and write high");
    end

endmodule : cache_arbiter_properties

bind arbiter_control cache_arbiter_properties props_i
(
    .clk          (clk),
    .rst          (rst),
    .icache_req_i (icache_req_i),
    .dcache_req_i (dcache_req_i),
    .line_req_i   (line_req_o),
    .icache_rsp_i (icache_rsp_o),
    .dcache_rsp_i (dcache_rsp_o)
);

/* hdl/cache_arbiter.sv */
`timescale 1ns/1ns

module cache_arbiter
(
    input  logic                  clk,
    input  logic                  rst,
    input  mem_bus_pkg::line_req_t icache_req_i,
    input  mem_bus_pkg::line_req_t dcache_req_i,
    input  mem_bus_pkg::pmem_rsp_t pmem_rsp_i,
    output mem_bus_pkg::line_rsp_t icache_rsp_o,
    output mem_bus_pkg::line_rsp_t dcache_rsp_o,
    output mem_bus_pkg::pmem_req_t pmem_req_o
);

    mem_bus_pkg::line_req_t arb_line_req; // Owner's request toward the adaptor
    mem_bus_pkg::line_rsp_t adp_line_rsp; // Assembled line back from the adaptor

    arbiter_control arbiter_i
    (
        .clk          (clk),
        .rst          (rst),
        .icache_req_i (icache_req_i),
        .dcache_req_i (dcache_req_i),
        .line_rsp_i   (adp_line_rsp),
        .line_req_o   (arb_line_req),
        .icache_rsp_o (icache_rsp_o),
        .dcache_rsp_o (dcache_rsp_o)
    );

    cacheline_adaptor adaptor_i
    (
        .clk        (clk),
        .rst        (rst),
        .line_req_i (arb_line_req),
        .pmem_rsp_i (pmem_rsp_i),
        .line_rsp_o (adp_line_rsp),
        .pmem_req_o (pmem_req_o)
    );

endmodule : cache_arbiter

/* hdl/cacheline_adaptor.sv */
`timescale 1ns/1ns

module cacheline_adaptor
(
    input  logic                  clk,
    input  logic                  rst,
    input  mem_bus_pkg::line_req_t line_req_i,
    input  mem_bus_pkg::pmem_rsp_t pmem_rsp_i,
    output mem_bus_pkg::line_rsp_t line_rsp_o,
    output mem_bus_pkg::pmem_req_t pmem_req_o
);

    localparam mem_bus_pkg::beat_idx_t LAST_BEAT =
        mem_bus_pkg::beat_idx_t'(mem_bus_pkg::BEATS_PER_LINE - 1);

    localparam int BASE_LSB = rv32i_types::LINE_OFFSET_BITS;

    typedef enum logic [1:0] {
        IDLE,
        BURST,
        DONE
    } adp_state_t;

    adp_state_t state;
    adp_state_t next_state;

    logic                   op_read;
    logic                   op_write;
    mem_bus_pkg::beat_idx_t beat_cnt;
    rv32i_types::rv32i_addr base_addr;
    mem_bus_pkg::line_t     line_buf; // Write line on the way out, read line on the way in

    logic start;
    logic beat_done;

    assign start = (state == IDLE) && (line_req_i.read || line_req_i.write);
    assign beat_done = (state == BURST) && pmem_rsp_i.resp;

    always_comb
    begin : next_state_logic
        next_state = state;

        unique case (state)
            IDLE:
            begin
                if (start)
                begin
                    next_state = BURST;
                end
            end
            BURST:
            begin
                if (beat_done && (beat_cnt == LAST_BEAT))
                begin
                    next_state = DONE;
                end
            end
            DONE: next_state = IDLE; // Single resp cycle
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin : control_regs
        if (rst)
        begin
            state <= IDLE;
            op_read <= 1'b0;
            op_write <= 1'b0;
            beat_cnt <= '0;
        end
        else
        begin
            state <= next_state;
            if (start)
            begin
                op_read <= line_req_i.read;
                op_write <= line_req_i.write;
                beat_cnt <= '0;
            end
            else if (beat_done)
            begin
                beat_cnt <= beat_cnt + 1'b1; // Wraps to zero after the last beat
            end
        end
    end

    always_ff @(posedge clk)
    begin : payload_regs
        if (start)
        begin
            base_addr <= line_req_i.addr;
            line_buf <= line_req_i.wdata;
        end
        else if (beat_done && op_read)
        begin
            line_buf[beat_cnt*mem_bus_pkg::BEAT_WIDTH +: mem_bus_pkg::BEAT_WIDTH] <=
                pmem_rsp_i.rdata;
        end
    end

    always_comb
    begin : pmem_drive
        pmem_req_o.read = (state == BURST) && op_read;
        pmem_req_o.write = (state == BURST) && op_write;
        pmem_req_o.addr = {base_addr[rv32i_types::XLEN-1:BASE_LSB], beat_cnt,
                           {mem_bus_pkg::BEAT_OFFSET_BITS{1'b0}}}; // Line base + 8 * beat
        pmem_req_o.wdata =
            line_buf[beat_cnt*mem_bus_pkg::BEAT_WIDTH +: mem_bus_pkg::BEAT_WIDTH];
    end

    assign line_rsp_o.resp = (state == DONE);
    assign line_rsp_o.rdata = line_buf;

endmodule : cacheline_adaptor

/* hdl/arbiter_control.sv */
`timescale 1ns/1ns

module arbiter_control
(
    input  logic                  clk,
    input  logic                  rst,
    input  mem_bus_pkg::line_req_t icache_req_i,
    input  mem_bus_pkg::line_req_t dcache_req_i,
    input  mem_bus_pkg::line_rsp_t line_rsp_i,
    output mem_bus_pkg::line_req_t line_req_o,
    output mem_bus_pkg::line_rsp_t icache_rsp_o,
    output mem_bus_pkg::line_rsp_t dcache_rsp_o
);

    typedef enum logic [1:0] {
        IDLE,
        I_CACHE,
        D_CACHE
    } arb_state_t;

    arb_state_t state;
    arb_state_t next_state;

    logic icache_pending;
    logic dcache_pending;
    logic granted;
    logic client_sel; // 0 selects I-cache, 1 selects D-cache

    assign icache_pending = icache_req_i.read | icache_req_i.write;
    assign dcache_pending = dcache_req_i.read | dcache_req_i.write;

    always_comb
    begin : state_actions
        granted = 1'b0;
        client_sel = 1'b0;
        icache_rsp_o.resp = 1'b0;
        dcache_rsp_o.resp = 1'b0;

        unique case (state)
            IDLE: ;
            I_CACHE:
            begin
                granted = 1'b1;
                icache_rsp_o.resp = line_rsp_i.resp;
            end
            D_CACHE:
            begin
                granted = 1'b1;
                client_sel = 1'b1;
                dcache_rsp_o.resp = line_rsp_i.resp;
            end
            default: ;
        endcase
    end

    // Whole request struct of the owner, zero while idle
    always_comb
    begin : request_route
        if (!granted)
        begin
            line_req_o = '0;
        end
        else if (client_sel)
        begin
            line_req_o = dcache_req_i;
        end
        else
        begin
            line_req_o = icache_req_i;
        end
    end

    // Only resp needs steering
    assign icache_rsp_o.rdata = line_rsp_i.rdata;
    assign dcache_rsp_o.rdata = line_rsp_i.rdata;

    always_comb
    begin : next_state_logic
        next_state = state;

        unique case (state)
            IDLE:
            begin
                if (icache_pending)
                begin
                    next_state = I_CACHE; // I-cache wins ties
                end
                else if (dcache_pending)
                begin
                    next_state = D_CACHE;
                end
            end
            I_CACHE:
            begin
                if (line_rsp_i.resp)
                begin
                    // Hand straight over to a waiting D-cache
                    next_state = dcache_pending ? D_CACHE : IDLE;
                end
            end
            D_CACHE:
            begin
                if (line_rsp_i.resp)
                begin
                    next_state = IDLE; // Gives a waiting I-cache its turn
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin : state_reg
        if (rst)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

endmodule : arbiter_control

/* hdl/mem_bus_pkg.sv */
package mem_bus_pkg;

    localparam int LINE_WIDTH = 256;
    localparam int BEAT_WIDTH = 64;
    localparam int BEATS_PER_LINE = LINE_WIDTH / BEAT_WIDTH;
    localparam int BEAT_IDX_BITS = $clog2(BEATS_PER_LINE);
    localparam int BEAT_OFFSET_BITS = $clog2(BEAT_WIDTH / 8); // Byte offset within a beat

    typedef logic [LINE_WIDTH-1:0] line_t;
    typedef logic [BEAT_WIDTH-1:0] beat_t;
    typedef logic [BEAT_IDX_BITS-1:0] beat_idx_t;

    // Cache side, one whole line per transfer
    typedef struct packed {
        logic                  read;
        logic                  write;
        rv32i_types::rv32i_addr addr;
        line_t                 wdata;
    } line_req_t;

    typedef struct packed {
        logic  resp;
        line_t rdata;
    } line_rsp_t;

    // Physical memory side, one beat per resp
    typedef struct packed {
        logic                  read;
        logic                  write;
        rv32i_types::rv32i_addr addr;
        beat_t                 wdata;
    } pmem_req_t;

    typedef struct packed {
        logic  resp;
        beat_t rdata;
    } pmem_rsp_t;

endpackage : mem_bus_pkg

/* hdl/rv32i_types.sv */
package rv32i_types;

    // Core-wide widths
    localparam int XLEN = 32;
    localparam int LINE_BYTES = 32;
    localparam int LINE_OFFSET_BITS = $clog2(LINE_BYTES); // Byte offset within a cache line

    typedef logic [XLEN-1:0] rv32i_word;

    // Byte address, same width as a data word
    typedef rv32i_word rv32i_addr;

endpackage : rv32i_types
